// File: backend_top.f
+incdir+verification
common/backend_pkg.sv
verilog/arch_regfile.sv
verilog/rename_table.sv
rob/rob.sv
verilog/alu_unit.sv
verilog/backend_ctrl.sv
verilog/backend_top.sv
verification/backend_tb.sv

// File: Bender.yml
package:
  name: backend_top

sources:
  - common/backend_pkg.sv
  - verilog/arch_regfile.sv
  - verilog/rename_table.sv
  - rob/rob.sv
  - verilog/alu_unit.sv
  - verilog/backend_ctrl.sv
  - verilog/backend_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/backend_tb.sv

// File: verification/backend_tb_model.svh
`ifndef BACKEND_TB_MODEL_SVH
`define BACKEND_TB_MODEL_SVH

// architectural state in program order
logic [XLEN-1:0] model_regs [NUM_ARCH_REGS];
retire_t         expected_q [$];
int              accepted_cnt;
int              retired_cnt;

task automatic clear_model();
  for (int r = 0; r < NUM_ARCH_REGS; r++) begin
    model_regs[r] = '0;
  end
  expected_q.delete();
  accepted_cnt = 0;
  retired_cnt  = 0;
endtask

function automatic logic [XLEN-1:0] model_result(input inst_t inst);
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [XLEN-1:0] res;
  a = model_regs[inst.rs1];
  if (inst.use_imm) begin
    b = {{(XLEN-16){inst.operand.imm[15]}}, inst.operand.imm};
  end else begin
    b = model_regs[inst.operand.r.rs2];
  end
  case (inst.op)
    ALU_OP_ADD: res = a + b;
    ALU_OP_SUB: res = a - b;
    ALU_OP_AND: res = a & b;
    ALU_OP_OR:  res = a | b;
    ALU_OP_XOR: res = a ^ b;
    ALU_OP_SLL: res = a << b[4:0];
    default:    res = '0;
  endcase
  return res;
endfunction

// r0 keeps zero but the retire still shows the computed value
task automatic accept_inst(input inst_t inst);
  retire_t exp;
  exp.valid = 1'b1;
  exp.rd    = inst.rd;
  exp.data  = model_result(inst);
  expected_q.push_back(exp);
  if (inst.rd != '0) begin
    model_regs[inst.rd] = exp.data;
  end
  accepted_cnt++;
endtask

`endif

// File: verification/backend_tb.sv
`timescale 1ns/1ps

module backend_tb import backend_pkg::*; ();

  localparam int WAIT_LIMIT   = 200;
  localparam int DRAIN_LIMIT  = 500;
  localparam int QUIET_CYCLES = 10;

  logic                      clk;
  logic                      rst_n;
  logic                      pkg_valid;
  logic                      pkg_ready;
  logic [ISSUE_WIDTH-1:0]    pkg_mask;
  inst_t [ISSUE_WIDTH-1:0]   pkg_inst;
  retire_t [ISSUE_WIDTH-1:0] retire;
  integer                    seed;
  logic                      saw_stall;

  `include "backend_tb_model.svh"

  backend_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .pkg_valid_i (pkg_valid),
    .pkg_ready_o (pkg_ready),
    .pkg_mask_i  (pkg_mask),
    .pkg_i       (pkg_inst),
    .retire_o    (retire)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_retire(input int lane, input retire_t got, input retire_t exp);
    if (got.rd !== exp.rd) begin
      stop_on_error($sformatf("Error at %0t: retire_o[%0d].rd got %0d expected %0d",
                              $time, lane, got.rd, exp.rd));
    end else if (got.data !== exp.data) begin
      stop_on_error($sformatf("Error at %0t: retire_o[%0d].data got %h expected %h",
                              $time, lane, got.data, exp.data));
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_on_error($sformatf("Error at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Error at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  function automatic arch_rid_t small_reg();
    return arch_rid_t'($unsigned($random(seed)) % 6);
  endfunction

  function automatic inst_t make_inst(input logic [2:0] op, input arch_rid_t rd,
                                      input arch_rid_t rs1, input logic use_imm,
                                      input logic [15:0] operand);
    inst_t inst;
    inst.op      = op;
    inst.rd      = rd;
    inst.rs1     = rs1;
    inst.use_imm = use_imm;
    inst.operand = operand;
    return inst;
  endfunction

  function automatic inst_t random_inst();
    inst_t inst;
    inst.op      = 3'($unsigned($random(seed)) % 6);
    inst.rd      = small_reg();
    inst.rs1     = small_reg();
    inst.use_imm = 1'($random(seed));
    inst.operand = 16'($random(seed));
    if (!inst.use_imm) begin
      inst.operand.r.rs2 = small_reg();
    end
    return inst;
  endfunction

  // enters and leaves 2 ns after a rising edge
  task automatic send_packet(input logic [1:0] mask, input inst_t i0, input inst_t i1);
    int   waited;
    logic taken;
    pkg_valid   = 1'b1;
    pkg_mask    = mask;
    pkg_inst[0] = i0;
    pkg_inst[1] = i1;
    waited      = 0;
    taken       = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = pkg_ready;
      @(posedge clk);
      #2;
      waited++;
      if (!taken && waited > WAIT_LIMIT) begin
        stop_on_error("packet was not accepted within the cycle limit");
      end
    end
    pkg_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // model update and retire check at mid-cycle
  always @(negedge clk) begin
    retire_t exp;
    if (rst_n) begin
      if (pkg_valid && pkg_ready) begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
          if (pkg_mask[l]) begin
            accept_inst(pkg_inst[l]);
          end
        end
      end
      if (!pkg_ready) begin
        saw_stall = 1'b1;
      end
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        if (retire[l].valid) begin
          if (expected_q.size() == 0) begin
            stop_on_error("retire_o reported an instruction that was never accepted");
          end else begin
            exp = expected_q.pop_front();
            compare_retire(l, retire[l], exp);
            retired_cnt++;
          end
        end
      end
    end
  end

  initial begin
    int waited;
    int quiet;
    seed      = 32'h3294;
    saw_stall = 1'b0;
    rst_n     = 1'b0;
    pkg_valid = 1'b0;
    pkg_mask  = '0;
    pkg_inst  = '0;
    clear_model();
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    compare_bit("pkg_ready_o", pkg_ready, 1'b1);
    compare_bit("retire_o[0].valid", retire[0].valid, 1'b0);
    compare_bit("retire_o[1].valid", retire[1].valid, 1'b0);
    @(posedge clk);
    #2;

    // zero reads, negative immediate, shift, chains and r0 writes
    send_packet(2'b11, make_inst(ALU_OP_OR, 5'd1, 5'd3, 1'b0, 16'd4),
                make_inst(ALU_OP_ADD, 5'd2, 5'd5, 1'b1, 16'hfffd));
    send_packet(2'b11, make_inst(ALU_OP_SLL, 5'd3, 5'd2, 1'b1, 16'd4),
                make_inst(ALU_OP_SUB, 5'd4, 5'd3, 1'b0, 16'd2));
    send_packet(2'b11, make_inst(ALU_OP_ADD, 5'd0, 5'd2, 1'b1, 16'd100),
                make_inst(ALU_OP_XOR, 5'd5, 5'd0, 1'b0, 16'd2));
    idle_cycles(3);

    // sparse traffic with gaps
    for (int p = 0; p < 40; p++) begin
      send_packet(2'($unsigned($random(seed)) % 3 + 1), random_inst(), random_inst());
      idle_cycles($unsigned($random(seed)) % 4);
    end

    // long dual-lane burst
    saw_stall = 1'b0;
    for (int p = 0; p < 80; p++) begin
      send_packet(2'b11, random_inst(), random_inst());
    end
    compare_bit("pkg_ready_o low during burst", saw_stall, 1'b1);

    // single-lane masks
    for (int p = 0; p < 30; p++) begin
      send_packet(($random(seed) & 1) ? 2'b10 : 2'b01, random_inst(), random_inst());
    end

    // drained once retire_o stays idle for a while
    waited = 0;
    quiet  = 0;
    while (quiet < QUIET_CYCLES) begin
      @(posedge clk);
      #2;
      waited++;
      if (retire[0].valid || retire[1].valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
      if (waited > DRAIN_LIMIT) begin
        stop_on_error("retire_o did not go idle within the drain limit");
      end
    end
    compare_count("retired instructions", retired_cnt, accepted_cnt);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: verilog/backend_top.sv
`timescale 1ns/1ps

module backend_top import backend_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    pkg_valid_i,
  output logic                    pkg_ready_o,
  input  logic [ISSUE_WIDTH-1:0]  pkg_mask_i,
  input  inst_t [ISSUE_WIDTH-1:0] pkg_i,
  output retire_t [ISSUE_WIDTH-1:0] retire_o
);

  arch_rid_t [2*ISSUE_WIDTH-1:0]           rf_raddr;
  logic [2*ISSUE_WIDTH-1:0][XLEN-1:0]      rf_rdata;
  logic [ISSUE_WIDTH-1:0]                  rf_we;
  arch_rid_t [ISSUE_WIDTH-1:0]             rf_waddr;
  logic [ISSUE_WIDTH-1:0][XLEN-1:0]        rf_wdata;
  logic [2*ISSUE_WIDTH-1:0]                rn_busy;
  rob_rid_t [2*ISSUE_WIDTH-1:0]            rn_slot;
  logic [ISSUE_WIDTH-1:0]                  rn_set;
  rob_rid_t [ISSUE_WIDTH-1:0]              rn_set_slot;
  logic [ISSUE_WIDTH-1:0]                  rn_clear;
  rob_rid_t [ISSUE_WIDTH-1:0]              rn_clear_slot;
  logic [ISSUE_WIDTH-1:0]                  rob_alloc;
  arch_rid_t [ISSUE_WIDTH-1:0]             rob_alloc_rd;
  rob_rid_t [ISSUE_WIDTH-1:0]              rob_alloc_slot;
  logic [1:0]                              rob_free;
  rob_rid_t [2*ISSUE_WIDTH-1:0]            rob_rslot;
  logic [2*ISSUE_WIDTH-1:0]                rob_rdone;
  logic [2*ISSUE_WIDTH-1:0][XLEN-1:0]      rob_rdata;
  rob_head_t [ISSUE_WIDTH-1:0]             rob_head;
  logic [1:0]                              rob_pop;
  cdb_t [ISSUE_WIDTH-1:0]                  cdb;
  dispatch_t [ISSUE_WIDTH-1:0]             disp;

  backend_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .pkg_valid_i      (pkg_valid_i),
    .pkg_ready_o      (pkg_ready_o),
    .pkg_mask_i       (pkg_mask_i),
    .pkg_i            (pkg_i),
    .rf_raddr_o       (rf_raddr),
    .rf_rdata_i       (rf_rdata),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .rn_busy_i        (rn_busy),
    .rn_slot_i        (rn_slot),
    .rn_set_o         (rn_set),
    .rn_set_slot_o    (rn_set_slot),
    .rn_clear_o       (rn_clear),
    .rn_clear_slot_o  (rn_clear_slot),
    .rob_alloc_o      (rob_alloc),
    .rob_alloc_rd_o   (rob_alloc_rd),
    .rob_alloc_slot_i (rob_alloc_slot),
    .rob_free_i       (rob_free),
    .rob_rslot_o      (rob_rslot),
    .rob_rdone_i      (rob_rdone),
    .rob_rdata_i      (rob_rdata),
    .rob_head_i       (rob_head),
    .rob_pop_o        (rob_pop),
    .cdb_i            (cdb),
    .disp_o           (disp),
    .retire_o         (retire_o)
  );

  arch_regfile u_arf (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata)
  );

  // set and clear register numbers match the alloc and retire ones
  rename_table u_rename (
    .clk          (clk),
    .rst_n        (rst_n),
    .rs_i         (rf_raddr),
    .busy_o       (rn_busy),
    .slot_o       (rn_slot),
    .set_i        (rn_set),
    .set_rd_i     (rob_alloc_rd),
    .set_slot_i   (rn_set_slot),
    .clear_i      (rn_clear),
    .clear_rd_i   (rf_waddr),
    .clear_slot_i (rn_clear_slot)
  );

  rob u_rob (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_i      (rob_alloc),
    .alloc_rd_i   (rob_alloc_rd),
    .alloc_slot_o (rob_alloc_slot),
    .free_o       (rob_free),
    .cdb_i        (cdb),
    .rslot_i      (rob_rslot),
    .rdone_o      (rob_rdone),
    .rdata_o      (rob_rdata),
    .head_o       (rob_head),
    .pop_i        (rob_pop)
  );

  alu_unit u_alu (
    .clk    (clk),
    .rst_n  (rst_n),
    .disp_i (disp),
    .cdb_o  (cdb)
  );

endmodule

// File: verilog/backend_ctrl.sv
`timescale 1ns/1ps

module backend_ctrl import backend_pkg::*; (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               pkg_valid_i,
  output logic                               pkg_ready_o,
  input  logic [ISSUE_WIDTH-1:0]             pkg_mask_i,
  input  inst_t [ISSUE_WIDTH-1:0]            pkg_i,
  output arch_rid_t [2*ISSUE_WIDTH-1:0]      rf_raddr_o,
  input  logic [2*ISSUE_WIDTH-1:0][XLEN-1:0] rf_rdata_i,
  output logic [ISSUE_WIDTH-1:0]             rf_we_o,
  output arch_rid_t [ISSUE_WIDTH-1:0]        rf_waddr_o,
  output logic [ISSUE_WIDTH-1:0][XLEN-1:0]   rf_wdata_o,
  input  logic [2*ISSUE_WIDTH-1:0]           rn_busy_i,
  input  rob_rid_t [2*ISSUE_WIDTH-1:0]       rn_slot_i,
  output logic [ISSUE_WIDTH-1:0]             rn_set_o,
  output rob_rid_t [ISSUE_WIDTH-1:0]         rn_set_slot_o,
  output logic [ISSUE_WIDTH-1:0]             rn_clear_o,
  output rob_rid_t [ISSUE_WIDTH-1:0]         rn_clear_slot_o,
  output logic [ISSUE_WIDTH-1:0]             rob_alloc_o,
  output arch_rid_t [ISSUE_WIDTH-1:0]        rob_alloc_rd_o,
  input  rob_rid_t [ISSUE_WIDTH-1:0]         rob_alloc_slot_i,
  input  logic [1:0]                         rob_free_i,
  output rob_rid_t [2*ISSUE_WIDTH-1:0]       rob_rslot_o,
  input  logic [2*ISSUE_WIDTH-1:0]           rob_rdone_i,
  input  logic [2*ISSUE_WIDTH-1:0][XLEN-1:0] rob_rdata_i,
  input  rob_head_t [ISSUE_WIDTH-1:0]        rob_head_i,
  output logic [1:0]                         rob_pop_o,
  input  cdb_t [ISSUE_WIDTH-1:0]             cdb_i,
  output dispatch_t [ISSUE_WIDTH-1:0]        disp_o,
  output retire_t [ISSUE_WIDTH-1:0]          retire_o
);

  logic                               skid_busy_q;
  logic [ISSUE_WIDTH-1:0]             skid_mask_q;
  inst_t [ISSUE_WIDTH-1:0]            skid_q;
  rob_rid_t                           ret_ptr_q;
  logic [ISSUE_WIDTH-1:0]             cur_mask;
  inst_t [ISSUE_WIDTH-1:0]            cur_pkg;
  logic [2*ISSUE_WIDTH-1:0]           src_rdy;
  logic [2*ISSUE_WIDTH-1:0][XLEN-1:0] src_val;
  logic [ISSUE_WIDTH-1:0]             lane_ok;
  logic                               lane1_dep;
  logic [ISSUE_WIDTH-1:0]             disp_go;
  logic [ISSUE_WIDTH-1:0]             ret_go;

  assign pkg_ready_o = !skid_busy_q;
  assign cur_pkg     = skid_busy_q ? skid_q : pkg_i;
  assign cur_mask    = skid_busy_q ? skid_mask_q : (pkg_valid_i ? pkg_mask_i : '0);

  // operand source from arf, rob entry or result bus
  always_comb begin
    logic            cdb_hit;
    logic [XLEN-1:0] cdb_data;
    logic            src_used;
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      for (int s = 0; s < 2; s++) begin
        rf_raddr_o[2*l+s]  = (s == 0) ? cur_pkg[l].rs1 : cur_pkg[l].operand.r.rs2;
        rob_rslot_o[2*l+s] = rn_slot_i[2*l+s];
        cdb_hit  = 1'b0;
        cdb_data = '0;
        for (int c = 0; c < ISSUE_WIDTH; c++) begin
          if (cdb_i[c].valid && cdb_i[c].slot == rn_slot_i[2*l+s]) begin
            cdb_hit  = 1'b1;
            cdb_data = cdb_i[c].data;
          end
        end
        src_used = (s == 0) || !cur_pkg[l].use_imm;
        src_rdy[2*l+s] = !src_used || !rn_busy_i[2*l+s] || rob_rdone_i[2*l+s] || cdb_hit;
        if (!rn_busy_i[2*l+s]) begin
          src_val[2*l+s] = rf_rdata_i[2*l+s];
        end else if (rob_rdone_i[2*l+s]) begin
          src_val[2*l+s] = rob_rdata_i[2*l+s];
        end else begin
          src_val[2*l+s] = cdb_data;
        end
      end
    end
  end

  // lane 1 waits a cycle when it reads lane 0's destination
  assign lane1_dep = cur_mask[0] && (cur_pkg[0].rd != '0) &&
                     ((cur_pkg[1].rs1 == cur_pkg[0].rd) ||
                      (!cur_pkg[1].use_imm && cur_pkg[1].operand.r.rs2 == cur_pkg[0].rd));

  assign disp_go[0] = lane_ok[0] && (rob_free_i != 2'd0);
  assign disp_go[1] = lane_ok[1] &&
                      (cur_mask[0] ? (disp_go[0] && !lane1_dep && rob_free_i == 2'd2)
                                   : (rob_free_i != 2'd0));

  // in-order retire from the two oldest entries
  assign ret_go[0] = rob_head_i[0].valid && rob_head_i[0].done;
  assign ret_go[1] = ret_go[0] && rob_head_i[1].valid && rob_head_i[1].done;
  assign rob_pop_o = 2'(ret_go[0]) + 2'(ret_go[1]);

  for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_lane
    assign lane_ok[l]        = cur_mask[l] && src_rdy[2*l] && src_rdy[2*l+1];
    assign rob_alloc_o[l]    = disp_go[l];
    assign rob_alloc_rd_o[l] = cur_pkg[l].rd;
    assign rn_set_o[l]       = disp_go[l];
    assign rn_set_slot_o[l]  = rob_alloc_slot_i[l];

    assign disp_o[l].valid = disp_go[l];
    assign disp_o[l].slot  = rob_alloc_slot_i[l];
    assign disp_o[l].op    = cur_pkg[l].op;
    assign disp_o[l].a     = src_val[2*l];
    assign disp_o[l].b     = cur_pkg[l].use_imm ?
        {{(XLEN-16){cur_pkg[l].operand.imm[15]}}, cur_pkg[l].operand.imm} : src_val[2*l+1];

    assign retire_o[l].valid   = ret_go[l];
    assign retire_o[l].rd      = rob_head_i[l].rd;
    assign retire_o[l].data    = rob_head_i[l].data;
    assign rf_we_o[l]          = ret_go[l];
    assign rf_waddr_o[l]       = rob_head_i[l].rd;
    assign rf_wdata_o[l]       = rob_head_i[l].data;
    assign rn_clear_o[l]       = ret_go[l];
    assign rn_clear_slot_o[l]  = ret_ptr_q + rob_rid_t'(l);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_busy_q <= 1'b0;
      skid_mask_q <= '0;
      ret_ptr_q   <= '0;
    end else begin
      // whatever did not dispatch stays behind
      skid_busy_q <= |(cur_mask & ~disp_go);
      skid_mask_q <= cur_mask & ~disp_go;
      ret_ptr_q   <= ret_ptr_q + rob_rid_t'(rob_pop_o);
    end
  end

  always_ff @(posedge clk) begin
    if (!skid_busy_q) begin
      skid_q <= pkg_i;
    end
  end

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import backend_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  dispatch_t [ISSUE_WIDTH-1:0] disp_i,
  output cdb_t [ISSUE_WIDTH-1:0]      cdb_o
);

  logic [ISSUE_WIDTH-1:0]           valid_q;
  rob_rid_t [ISSUE_WIDTH-1:0]       slot_q;
  logic [ISSUE_WIDTH-1:0][XLEN-1:0] data_q;

  function automatic logic [XLEN-1:0] alu_calc(input logic [2:0] op,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
    case (op)
      ALU_OP_ADD: return a + b;
      ALU_OP_SUB: return a - b;
      ALU_OP_AND: return a & b;
      ALU_OP_OR:  return a | b;
      ALU_OP_XOR: return a ^ b;
      ALU_OP_SLL: return a << b[4:0];
      default:    return '0;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        valid_q[l] <= disp_i[l].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      slot_q[l] <= disp_i[l].slot;
      data_q[l] <= alu_calc(disp_i[l].op, disp_i[l].a, disp_i[l].b);
    end
  end

  for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_cdb
    assign cdb_o[l].valid = valid_q[l];
    assign cdb_o[l].slot  = slot_q[l];
    assign cdb_o[l].data  = data_q[l];
  end

endmodule

// File: rob/rob.sv
`timescale 1ns/1ps

module rob import backend_pkg::*; (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [ISSUE_WIDTH-1:0]             alloc_i,
  input  arch_rid_t [ISSUE_WIDTH-1:0]        alloc_rd_i,
  output rob_rid_t [ISSUE_WIDTH-1:0]         alloc_slot_o,
  output logic [1:0]                         free_o,
  input  cdb_t [ISSUE_WIDTH-1:0]             cdb_i,
  input  rob_rid_t [2*ISSUE_WIDTH-1:0]       rslot_i,
  output logic [2*ISSUE_WIDTH-1:0]           rdone_o,
  output logic [2*ISSUE_WIDTH-1:0][XLEN-1:0] rdata_o,
  output rob_head_t [ISSUE_WIDTH-1:0]        head_o,
  input  logic [1:0]                         pop_i
);

  logic [ROB_DEPTH-1:0]           done_q;
  arch_rid_t [ROB_DEPTH-1:0]      rd_q;
  logic [ROB_DEPTH-1:0][XLEN-1:0] data_q;
  rob_rid_t                       head_q;
  rob_rid_t                       tail_q;
  logic [ROB_IDX_W:0]             count_q;
  logic [ROB_IDX_W:0]             free_cnt;
  logic [ROB_IDX_W:0]             alloc_cnt;

  assign alloc_cnt = (ROB_IDX_W+1)'(alloc_i[0]) + (ROB_IDX_W+1)'(alloc_i[1]);

  // lane 1 takes the slot after lane 0 only if lane 0 allocates
  assign alloc_slot_o[0] = tail_q;
  assign alloc_slot_o[1] = tail_q + rob_rid_t'(alloc_i[0]);

  assign free_cnt = (ROB_IDX_W+1)'(ROB_DEPTH) - count_q;
  assign free_o   = (free_cnt >= 2) ? 2'd2 : free_cnt[1:0];

  for (genvar r = 0; r < 2*ISSUE_WIDTH; r++) begin : g_read
    assign rdone_o[r] = done_q[rslot_i[r]];
    assign rdata_o[r] = data_q[rslot_i[r]];
  end

  for (genvar h = 0; h < ISSUE_WIDTH; h++) begin : g_head
    rob_rid_t hslot;
    assign hslot          = head_q + rob_rid_t'(h);
    assign head_o[h].valid = count_q > h;
    assign head_o[h].done  = done_q[hslot];
    assign head_o[h].rd    = rd_q[hslot];
    assign head_o[h].data  = data_q[hslot];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      head_q  <= head_q + rob_rid_t'(pop_i);
      tail_q  <= tail_q + rob_rid_t'(alloc_cnt);
      count_q <= count_q + alloc_cnt - (ROB_IDX_W+1)'(pop_i);
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        if (alloc_i[l]) begin
          done_q[alloc_slot_o[l]] <= 1'b0;
        end
      end
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        if (cdb_i[l].valid) begin
          done_q[cdb_i[l].slot] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      if (alloc_i[l]) begin
        rd_q[alloc_slot_o[l]] <= alloc_rd_i[l];
      end
      if (cdb_i[l].valid) begin
        data_q[cdb_i[l].slot] <= cdb_i[l].data;
      end
    end
  end

endmodule

// File: verilog/rename_table.sv
`timescale 1ns/1ps

module rename_table import backend_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  arch_rid_t [2*ISSUE_WIDTH-1:0] rs_i,
  output logic [2*ISSUE_WIDTH-1:0]      busy_o,
  output rob_rid_t [2*ISSUE_WIDTH-1:0]  slot_o,
  input  logic [ISSUE_WIDTH-1:0]        set_i,
  input  arch_rid_t [ISSUE_WIDTH-1:0]   set_rd_i,
  input  rob_rid_t [ISSUE_WIDTH-1:0]    set_slot_i,
  input  logic [ISSUE_WIDTH-1:0]        clear_i,
  input  arch_rid_t [ISSUE_WIDTH-1:0]   clear_rd_i,
  input  rob_rid_t [ISSUE_WIDTH-1:0]    clear_slot_i
);

  logic [NUM_ARCH_REGS-1:0]     busy_q;
  rob_rid_t [NUM_ARCH_REGS-1:0] slot_q;

  for (genvar r = 0; r < 2*ISSUE_WIDTH; r++) begin : g_read
    assign busy_o[r] = busy_q[rs_i[r]];
    assign slot_o[r] = slot_q[rs_i[r]];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else begin
      // only the youngest producer may release the register
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        if (clear_i[l] && slot_q[clear_rd_i[l]] == clear_slot_i[l]) begin
          busy_q[clear_rd_i[l]] <= 1'b0;
        end
      end
      // new rename overrides a same-cycle release
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        if (set_i[l] && set_rd_i[l] != '0) begin
          busy_q[set_rd_i[l]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      if (set_i[l] && set_rd_i[l] != '0) begin
        slot_q[set_rd_i[l]] <= set_slot_i[l];
      end
    end
  end

endmodule

// File: verilog/arch_regfile.sv
`timescale 1ns/1ps

module arch_regfile import backend_pkg::*; (
  input  logic                               clk,
  input  logic                               rst_n,
  input  arch_rid_t [2*ISSUE_WIDTH-1:0]      raddr_i,
  output logic [2*ISSUE_WIDTH-1:0][XLEN-1:0] rdata_o,
  input  logic [ISSUE_WIDTH-1:0]             we_i,
  input  arch_rid_t [ISSUE_WIDTH-1:0]        waddr_i,
  input  logic [ISSUE_WIDTH-1:0][XLEN-1:0]   wdata_i
);

  logic [NUM_ARCH_REGS-1:0][XLEN-1:0] regs_q;

  // later lane written last, so it wins on the same rd
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regs_q <= '0;
    end else begin
      for (int w = 0; w < ISSUE_WIDTH; w++) begin
        if (we_i[w] && waddr_i[w] != '0) begin
          regs_q[waddr_i[w]] <= wdata_i[w];
        end
      end
    end
  end

  always_comb begin
    for (int r = 0; r < 2*ISSUE_WIDTH; r++) begin
      rdata_o[r] = regs_q[raddr_i[r]];
      for (int w = 0; w < ISSUE_WIDTH; w++) begin
        if (we_i[w] && waddr_i[w] != '0 && waddr_i[w] == raddr_i[r]) begin
          rdata_o[r] = wdata_i[w];
        end
      end
    end
  end

endmodule

// File: common/backend_pkg.sv
package backend_pkg;

  localparam int XLEN          = 32;
  localparam int NUM_ARCH_REGS = 32;
  localparam int ROB_DEPTH     = 8;
  localparam int ROB_IDX_W     = 3;
  localparam int ISSUE_WIDTH   = 2;

  localparam logic [2:0] ALU_OP_ADD = 3'd0;
  localparam logic [2:0] ALU_OP_SUB = 3'd1;
  localparam logic [2:0] ALU_OP_AND = 3'd2;
  localparam logic [2:0] ALU_OP_OR  = 3'd3;
  localparam logic [2:0] ALU_OP_XOR = 3'd4;
  localparam logic [2:0] ALU_OP_SLL = 3'd5;

  typedef logic [4:0]           arch_rid_t;
  typedef logic [ROB_IDX_W-1:0] rob_rid_t;

  typedef struct packed {
    logic [10:0] unused;
    arch_rid_t   rs2;
  } reg_form_t;

  // second operand word decoded by use_imm
  typedef union packed {
    reg_form_t          r;
    logic signed [15:0] imm;
  } operand_u;

  typedef struct packed {
    logic [2:0] op;
    arch_rid_t  rd;
    arch_rid_t  rs1;
    logic       use_imm;
    operand_u   operand;
  } inst_t;

  typedef struct packed {
    logic            valid;
    rob_rid_t        slot;
    logic [2:0]      op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } dispatch_t;

  typedef struct packed {
    logic            valid;
    rob_rid_t        slot;
    logic [XLEN-1:0] data;
  } cdb_t;

  typedef struct packed {
    logic            valid;
    logic            done;
    arch_rid_t       rd;
    logic [XLEN-1:0] data;
  } rob_head_t;

  typedef struct packed {
    logic            valid;
    arch_rid_t       rd;
    logic [XLEN-1:0] data;
  } retire_t;

endpackage
